/* test/fetch_vectors.txt */
# L index way tag present data   (cache line, byte 0 in the low bits)
# P vpn ppn page_fault access_fault
# E pc valid redirect after_pc fault / R pc asid mode vm / D pc / W / B taken start target
# S stall_cycles / X idle_cycles / Q drain expected / T test_name
L 00 0 000004 1 100e100c100a10081006100410021000
L 01 0 000004 1 101e101c101a10181016101410121010
L 02 0 000004 1 102e102c102a10281026102410221020
L 03 0 000004 0 103e103c103a10381036103410321030
L 10 0 000004 1 110e110c110a11081106110411021100
L 20 0 000004 1 120e120c120a12081206120412021200
P 00040 00001 0 0
P 00050 00002 1 0
E 00001006 f8 00 00001010 0
E 00001010 ff 00 00001020 0
E 00001020 ff 00 00001030 0
R 00001006 000 3 0
Q
W
T sequential
E 00001030 ff 00 00001040 0
D 00001030
Q
W
T miss_refill
B 1 00001104 00001200
E 00001100 07 04 00001200 0
E 00001200 ff 00 00001210 0
D 00001100
Q
W
B 0 00001104 00000000
E 00001100 ff 00 00001110 0
D 00001100
Q
W
T branch
E 00040020 ff 00 00040030 0
E 00040030 ff 00 00040040 0
R 00040020 005 0 1
Q
W
E 00050000 00 00 00050010 1
R 00050000 005 0 1
Q
X 10
T virtual_fault
E 00001010 ff 00 00001020 0
E 00001020 ff 00 00001030 0
R 00001010 000 3 0
S 12
Q
W
X 10
E 00001000 ff 00 00001010 0
D 00001000
Q
W
T wait_stall

/* tb.f */
source/fetch_pkg.sv
source/fetch_pc_control.sv
source/fetch_btb.sv
source/fetch_tag_compare.sv
source/fetch_unit.sv
source/fetch_unit_wrapper.sv
test/fetch_unit_asserts.sv
test/tb_fetch_unit.sv

/* Makefile */
SIM = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP = tb_fetch_unit
FILE_LIST = tb.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_fetch_unit.sv */
// fetch unit testbench
// models the instruction TLB and cache, runs the commands of the vector file
// and checks every istream packet against the expected list
module tb_fetch_unit;
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;

	typedef struct packed {
		pc_t pc;
		logic [7:0] valid;
		logic [7:0] redirect;
		pc_t after_pc;
		logic fault;
	} expect_t;

	logic CLK;
	logic nRST;
	itlb_req_t last_itlb_req;
	itlb_resp_t next_itlb_resp;
	icache_req_t last_icache_req;
	icache_resp_t next_icache_resp;
	icache_feedback_t last_icache_feedback;
	istream_t last_istream;
	logic next_istream_stall;
	rob_restart_t next_rob_restart;
	decode_restart_t next_decode_restart;
	logic next_trigger_wait_for_restart;
	branch_update_t next_branch_update;

	fetch_unit_wrapper DUT (.*);

	// cache contents and backing lines
	logic cache_valid [64][2];
	icache_tag_t cache_tag [64][2];
	logic [127:0] cache_data [64][2];
	icache_index_t line_idx [$];
	icache_tag_t line_tag [$];
	logic [127:0] line_data [$];
	// page map
	vpn_t page_vpn [$];
	ppn_t page_ppn [$];
	logic page_pf [$];
	logic page_af [$];

	string cmds [$];
	expect_t exp_q [$];
	int cycle;
	int limit;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int req_cycle;
	icache_index_t req_index;
	logic stall_q;
	logic cur_vm;
	asid_t cur_asid;
	exec_mode_t cur_mode;

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// ------------------------------
	// watchdog
	initial begin
		int n;
		n = 0;
		wait (limit > 0);
		while (n < limit) begin
			@(posedge CLK);
			n++;
		end
		$display("timeout: run stopped after %0d cycles", n);
		$display("TEST FAILED");
		$finish;
	end

	function automatic int find_page(vpn_t vpn);
		foreach (page_vpn[i]) begin
			if (page_vpn[i] == vpn) return i;
		end
		return -1;
	endfunction

	function automatic int find_line(icache_index_t idx, icache_tag_t tag);
		foreach (line_idx[i]) begin
			if (line_idx[i] == idx && line_tag[i] == tag) return i;
		end
		return -1;
	endfunction

	// physical tag of a PC under the current mode
	function automatic icache_tag_t expected_tag(pc_t pc);
		int p;
		ppn_t ppn;
		ppn = pc[31:12];
		if (cur_vm) begin
			p = find_page(pc[31:12]);
			if (p >= 0) ppn = page_ppn[p];
		end
		return {ppn, pc[11:10]};
	endfunction

	// page and access fault flags of a page
	// missing pages raise a page fault
	function automatic logic [1:0] expected_faults(pc_t pc);
		int p;
		p = find_page(pc[31:12]);
		if (p < 0) return 2'b10;
		return {page_pf[p], page_af[p]};
	endfunction

	task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] got);
		$display("MISMATCH t=%0t %s expected=%h got=%h", $time, name, exp, got);
		errors++;
		test_errors++;
	endtask

	task automatic fail_msg(string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
		test_errors++;
	endtask

	task automatic check_packet();
		expect_t e;
		int l;
		logic [1:0] f;
		icache_tag_t tag;
		logic way;
		if (exp_q.size() == 0) begin
			fail_msg("packet arrived with nothing expected");
			return;
		end
		e = exp_q.pop_front();
		if (cycle - req_cycle != 2) fail_msg("packet not 2 cycles after its cache request");
		if (last_istream.valid_by_parcel !== e.valid)
			report_mismatch("valid_by_parcel", 128'(e.valid), 128'(last_istream.valid_by_parcel));
		if (last_istream.redirect_by_parcel !== e.redirect)
			report_mismatch("redirect_by_parcel", 128'(e.redirect),
				128'(last_istream.redirect_by_parcel));
		if (last_istream.after_pc !== e.after_pc)
			report_mismatch("after_pc", 128'(e.after_pc), 128'(last_istream.after_pc));
		if ((last_istream.page_fault | last_istream.access_fault) !== e.fault)
			report_mismatch("fault", 128'(e.fault),
				128'(last_istream.page_fault | last_istream.access_fault));
		if (e.fault) begin
			f = expected_faults(e.pc);
			if (last_istream.page_fault !== f[1])
				report_mismatch("page_fault", 128'(f[1]), 128'(last_istream.page_fault));
			if (last_istream.access_fault !== f[0])
				report_mismatch("access_fault", 128'(f[0]), 128'(last_istream.access_fault));
		end else begin
			if (!last_icache_feedback.hit_valid) fail_msg("hit packet without hit feedback");
			tag = expected_tag(e.pc);
			l = find_line(e.pc[9:4], tag);
			if (l < 0) begin
				fail_msg("no cache line for an expected packet");
			end else if (last_istream.parcels !== line_data[l]) begin
				report_mismatch("parcels", line_data[l], last_istream.parcels);
			end
			// way 0 wins when both ways hold the line
			if (cache_valid[e.pc[9:4]][0] && cache_tag[e.pc[9:4]][0] == tag) begin
				way = 1'b0;
			end else begin
				way = 1'b1;
			end
			if (last_icache_feedback.hit_way !== way)
				report_mismatch("hit_way", 128'(way), 128'(last_icache_feedback.hit_way));
		end
	endtask

	// ------------------------------
	// output checks and refill
	task automatic monitor_outputs();
		int l;
		if (last_icache_req.valid) begin
			if (stall_q) fail_msg("cache request while stalled");
			if (cur_vm && !last_itlb_req.valid) fail_msg("virtual mode request without TLB");
			if (!cur_vm && last_itlb_req.valid) fail_msg("TLB request in physical mode");
			if (exp_q.size() > 0) begin
				if (last_icache_req.index !== exp_q[0].pc[9:4])
					report_mismatch("icache_req.index", 128'(exp_q[0].pc[9:4]),
						128'(last_icache_req.index));
				if (last_itlb_req.virtual_mode !== cur_vm)
					report_mismatch("itlb_req.virtual_mode", 128'(cur_vm),
						128'(last_itlb_req.virtual_mode));
				if (last_itlb_req.valid && last_itlb_req.asid !== cur_asid)
					report_mismatch("itlb_req.asid", 128'(cur_asid), 128'(last_itlb_req.asid));
				if (last_itlb_req.valid && last_itlb_req.exec_mode !== cur_mode)
					report_mismatch("itlb_req.exec_mode", 128'(cur_mode),
						128'(last_itlb_req.exec_mode));
				if (last_itlb_req.valid && last_itlb_req.vpn !== exp_q[0].pc[31:12])
					report_mismatch("itlb_req.vpn", 128'(exp_q[0].pc[31:12]),
						128'(last_itlb_req.vpn));
			end
			req_cycle = cycle;
			req_index = last_icache_req.index;
		end
		if (last_icache_feedback.miss_valid) begin
			if (exp_q.size() > 0 && last_icache_feedback.miss_tag !== expected_tag(exp_q[0].pc))
				report_mismatch("miss_tag", 128'(expected_tag(exp_q[0].pc)),
					128'(last_icache_feedback.miss_tag));
			l = find_line(req_index, last_icache_feedback.miss_tag);
			if (l < 0) begin
				fail_msg("miss on a line the memory model does not hold");
			end else begin
				// refill into way 1
				cache_valid[req_index][1] = 1'b1;
				cache_tag[req_index][1] = line_tag[l];
				cache_data[req_index][1] = line_data[l];
			end
		end
		if (last_istream.valid) check_packet();
		stall_q = next_istream_stall;
	endtask

	// TLB and cache answer the request seen this cycle
	task automatic model_memories();
		int p;
		next_icache_resp = '0;
		next_itlb_resp = '0;
		if (last_icache_req.valid) begin
			for (int w = 0; w < 2; w++) begin
				next_icache_resp.valid_by_way[w] = cache_valid[last_icache_req.index][w];
				next_icache_resp.tag_by_way[w] = cache_tag[last_icache_req.index][w];
				next_icache_resp.block_by_way[w] = cache_data[last_icache_req.index][w];
			end
		end
		if (last_itlb_req.valid) begin
			p = find_page(last_itlb_req.vpn);
			next_itlb_resp.valid = 1'b1;
			if (p >= 0) begin
				next_itlb_resp.ppn = page_ppn[p];
				next_itlb_resp.page_fault = page_pf[p];
				next_itlb_resp.access_fault = page_af[p];
			end else begin
				next_itlb_resp.page_fault = 1'b1;
			end
		end
	endtask

	task automatic tick();
		@(negedge CLK);
		cycle++;
		monitor_outputs();
		model_memories();
		next_rob_restart = '0;
		next_decode_restart = '0;
		next_trigger_wait_for_restart = 1'b0;
		next_branch_update = '0;
	endtask

	// ------------------------------
	// vector file
	task automatic load_vectors();
		int fd;
		string line;
		string kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [127:0] data;
		fd = $fopen("test/fetch_vectors.txt", "r");
		if (fd == 0) begin
			fail_msg("cannot open the vector file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if ($sscanf(line, "%s", kind) != 1) continue;
				if (kind[0] == 8'h23) continue;
				if (kind == "L") begin
					void'($sscanf(line, "%s %h %h %h %h %h", kind, a, b, c, d, data));
					line_idx.push_back(a[5:0]);
					line_tag.push_back(c[21:0]);
					line_data.push_back(data);
					if (d[0]) begin
						cache_valid[a[5:0]][b[0]] = 1'b1;
						cache_tag[a[5:0]][b[0]] = c[21:0];
						cache_data[a[5:0]][b[0]] = data;
					end
				end else if (kind == "P") begin
					void'($sscanf(line, "%s %h %h %h %h", kind, a, b, c, d));
					page_vpn.push_back(a[19:0]);
					page_ppn.push_back(b[19:0]);
					page_pf.push_back(c[0]);
					page_af.push_back(d[0]);
				end else begin
					cmds.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_command(string line);
		string kind;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		int n;
		expect_t x;
		void'($sscanf(line, "%s", kind));
		case (kind)
			"E": begin
				void'($sscanf(line, "%s %h %h %h %h %h", kind, a, b, c, d, e));
				x.pc = a;
				x.valid = b[7:0];
				x.redirect = c[7:0];
				x.after_pc = d;
				x.fault = e[0];
				exp_q.push_back(x);
			end
			"R": begin
				void'($sscanf(line, "%s %h %h %h %h", kind, a, b, c, d));
				next_rob_restart.valid = 1'b1;
				next_rob_restart.pc = a;
				next_rob_restart.asid = b[8:0];
				next_rob_restart.exec_mode = c[1:0];
				next_rob_restart.virtual_mode = d[0];
				cur_asid = b[8:0];
				cur_mode = c[1:0];
				cur_vm = d[0];
				tick();
			end
			"D": begin
				void'($sscanf(line, "%s %h", kind, a));
				next_decode_restart.valid = 1'b1;
				next_decode_restart.pc = a;
				tick();
			end
			"W": begin
				next_trigger_wait_for_restart = 1'b1;
				tick();
				// let the request in flight drain
				repeat (4) tick();
			end
			"B": begin
				void'($sscanf(line, "%s %h %h %h", kind, a, b, c));
				next_branch_update.valid = 1'b1;
				next_branch_update.is_taken = a[0];
				next_branch_update.start_pc = b;
				next_branch_update.target_pc = c;
				tick();
			end
			"S": begin
				void'($sscanf(line, "%s %d", kind, n));
				// stall only while packets are still due
				repeat (n) begin
					if (exp_q.size() > 0) begin
						next_istream_stall = ($urandom % 2) != 0;
						tick();
					end
				end
				next_istream_stall = 1'b0;
			end
			"Q": begin
				while (exp_q.size() > 0) tick();
			end
			"X": begin
				void'($sscanf(line, "%s %d", kind, n));
				repeat (n) begin
					tick();
					if (last_icache_req.valid) fail_msg("cache request while fetch is parked");
				end
			end
			"T": begin
				void'($sscanf(line, "%s %s", kind, name));
				tests_run++;
				if (test_errors == 0) begin
					$display("done %s: ok", name);
				end else begin
					$display("done %s: %0d errors", name, test_errors);
					tests_failed++;
				end
				test_errors = 0;
			end
			default: fail_msg("unknown command in the vector file");
		endcase
	endtask

	// ------------------------------
	// main sequence
	initial begin
		nRST = 1'b0;
		next_itlb_resp = '0;
		next_icache_resp = '0;
		next_istream_stall = 1'b0;
		next_rob_restart = '0;
		next_decode_restart = '0;
		next_trigger_wait_for_restart = 1'b0;
		next_branch_update = '0;
		cycle = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		req_cycle = 0;
		req_index = '0;
		stall_q = 1'b0;
		cur_vm = 1'b0;
		cur_asid = '0;
		cur_mode = '0;
		void'($urandom(98));
		for (int i = 0; i < 64; i++) begin
			for (int w = 0; w < 2; w++) begin
				cache_valid[i][w] = 1'b0;
				cache_tag[i][w] = '0;
				cache_data[i][w] = '0;
			end
		end
		load_vectors();
		limit = cmds.size() * 40;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		foreach (cmds[i]) run_command(cmds[i]);
		if (exp_q.size() != 0) fail_msg("expected packets never arrived");
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* test/fetch_unit_asserts.sv */
// fetch unit protocol checks
// bound into the fetch unit core
module fetch_unit_asserts (
	input logic CLK,
	input logic nRST,
	input fetch_pkg::itlb_req_t itlb_req,
	input fetch_pkg::icache_req_t icache_req,
	input fetch_pkg::icache_feedback_t icache_feedback,
	input fetch_pkg::istream_t istream
);
	timeunit 1ns;
	timeprecision 1ps;

	// REQ lasts one cycle
	single_req: assert property (@(posedge CLK) disable iff (!nRST)
		icache_req.valid |=> !icache_req.valid)
		else $error("cache request held for two cycles");

	// RESP comes two cycles after the request that fed it
	packet_after_req: assert property (@(posedge CLK) disable iff (!nRST)
		istream.valid |-> $past(icache_req.valid, 2))
		else $error("istream packet without a cache request two cycles before");

	feedback_after_req: assert property (@(posedge CLK) disable iff (!nRST)
		icache_feedback.hit_valid || icache_feedback.miss_valid
		|-> $past(icache_req.valid, 2))
		else $error("cache feedback without a cache request two cycles before");

	fault_after_tlb_req: assert property (@(posedge CLK) disable iff (!nRST)
		istream.valid && (istream.page_fault || istream.access_fault)
		|-> $past(itlb_req.valid, 2))
		else $error("fault packet without a TLB request two cycles before");

endmodule

bind fetch_unit fetch_unit_asserts protocol_checks (
	.CLK(CLK),
	.nRST(nRST),
	.itlb_req(itlb_req),
	.icache_req(icache_req),
	.icache_feedback(icache_feedback),
	.istream(istream)
);

/* source/fetch_unit_wrapper.sv */
// fetch unit wrapper
// top level with one register on every fetch unit input and output
module fetch_unit_wrapper (
	input logic CLK,
	input logic nRST,
	output fetch_pkg::itlb_req_t last_itlb_req,
	input fetch_pkg::itlb_resp_t next_itlb_resp,
	output fetch_pkg::icache_req_t last_icache_req,
	input fetch_pkg::icache_resp_t next_icache_resp,
	output fetch_pkg::icache_feedback_t last_icache_feedback,
	output fetch_pkg::istream_t last_istream,
	input logic next_istream_stall,
	input fetch_pkg::rob_restart_t next_rob_restart,
	input fetch_pkg::decode_restart_t next_decode_restart,
	input logic next_trigger_wait_for_restart,
	input fetch_pkg::branch_update_t next_branch_update
);
	import fetch_pkg::*;

	// ------------------------------
	// core side
	itlb_req_t itlb_req;
	itlb_resp_t itlb_resp;
	icache_req_t icache_req;
	icache_resp_t icache_resp;
	icache_feedback_t icache_feedback;
	istream_t istream;
	logic istream_stall;
	rob_restart_t rob_restart;
	decode_restart_t decode_restart;
	logic trigger_wait_for_restart;
	branch_update_t branch_update;

	fetch_unit WRAPPED_MODULE (.*);

	// ------------------------------
	// boundary registers
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// outputs
			last_itlb_req <= '0;
			last_icache_req <= '0;
			last_icache_feedback <= '0;
			last_istream <= '0;
			// inputs
			itlb_resp <= '0;
			icache_resp <= '0;
			istream_stall <= 1'b0;
			rob_restart <= '0;
			decode_restart <= '0;
			trigger_wait_for_restart <= 1'b0;
			branch_update <= '0;
		end else begin
			last_itlb_req <= itlb_req;
			last_icache_req <= icache_req;
			last_icache_feedback <= icache_feedback;
			last_istream <= istream;
			itlb_resp <= next_itlb_resp;
			icache_resp <= next_icache_resp;
			istream_stall <= next_istream_stall;
			rob_restart <= next_rob_restart;
			decode_restart <= next_decode_restart;
			trigger_wait_for_restart <= next_trigger_wait_for_restart;
			branch_update <= next_branch_update;
		end
	end

endmodule

/* source/fetch_unit.sv */
// fetch unit
// PC control, branch target buffer and tag compare for one 16-byte
// fetch block per request
module fetch_unit (
	input logic CLK,
	input logic nRST,
	output fetch_pkg::itlb_req_t itlb_req,
	input fetch_pkg::itlb_resp_t itlb_resp,
	output fetch_pkg::icache_req_t icache_req,
	input fetch_pkg::icache_resp_t icache_resp,
	output fetch_pkg::icache_feedback_t icache_feedback,
	output fetch_pkg::istream_t istream,
	input logic istream_stall,
	input fetch_pkg::rob_restart_t rob_restart,
	input fetch_pkg::decode_restart_t decode_restart,
	input logic trigger_wait_for_restart,
	input fetch_pkg::branch_update_t branch_update
);
	import fetch_pkg::*;

	pc_t fetch_pc;
	logic resp_cycle;
	logic pred_hit;
	parcel_idx_t pred_parcel;
	pc_t pred_target;
	logic resolve_hit;
	logic resolve_miss;
	logic resolve_fault;
	pc_t after_pc;

	fetch_pc_control pc_control (
		.CLK(CLK),
		.nRST(nRST),
		.rob_restart(rob_restart),
		.decode_restart(decode_restart),
		.trigger_wait_for_restart(trigger_wait_for_restart),
		.istream_stall(istream_stall),
		.resolve_hit(resolve_hit),
		.resolve_miss(resolve_miss),
		.resolve_fault(resolve_fault),
		.after_pc(after_pc),
		.fetch_pc(fetch_pc),
		.itlb_req(itlb_req),
		.icache_req(icache_req),
		.resp_cycle(resp_cycle)
	);

	fetch_btb btb (
		.CLK(CLK),
		.nRST(nRST),
		.fetch_pc(fetch_pc),
		.branch_update(branch_update),
		.pred_hit(pred_hit),
		.pred_parcel(pred_parcel),
		.pred_target(pred_target)
	);

	// mode travels with the TLB request fields
	fetch_tag_compare tag_compare (
		.resp_cycle(resp_cycle),
		.fetch_pc(fetch_pc),
		.virtual_mode(itlb_req.virtual_mode),
		.itlb_resp(itlb_resp),
		.icache_resp(icache_resp),
		.pred_hit(pred_hit),
		.pred_parcel(pred_parcel),
		.pred_target(pred_target),
		.resolve_hit(resolve_hit),
		.resolve_miss(resolve_miss),
		.resolve_fault(resolve_fault),
		.after_pc(after_pc),
		.icache_feedback(icache_feedback),
		.istream(istream)
	);

endmodule

/* source/fetch_tag_compare.sv */
// fetch tag compare
// checks both cache ways against the physical tag, decides hit, miss or
// fault, and builds the instruction stream packet
module fetch_tag_compare (
	input logic resp_cycle,
	input fetch_pkg::pc_t fetch_pc,
	input logic virtual_mode,
	input fetch_pkg::itlb_resp_t itlb_resp,
	input fetch_pkg::icache_resp_t icache_resp,
	input logic pred_hit,
	input fetch_pkg::parcel_idx_t pred_parcel,
	input fetch_pkg::pc_t pred_target,
	output logic resolve_hit,
	output logic resolve_miss,
	output logic resolve_fault,
	output fetch_pkg::pc_t after_pc,
	output fetch_pkg::icache_feedback_t icache_feedback,
	output fetch_pkg::istream_t istream
);
	import fetch_pkg::*;

	ppn_t ppn;
	icache_tag_t phys_tag;
	logic [1:0] way_hit;
	logic hit_way;
	logic tlb_ready;
	logic tlb_fault;
	parcel_idx_t end_parcel;
	logic [FETCH_PARCELS-1:0] parcel_mask;
	logic [FETCH_PARCELS-1:0] redirect_mask;
	pc_t block_base;

	// ------------------------------
	// tag check
	always_comb begin
		// physical mode maps the PC straight through
		ppn = virtual_mode ? itlb_resp.ppn : fetch_pc[31:12];
		phys_tag = {ppn, fetch_pc[11:10]};
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = icache_resp.valid_by_way[w]
				&& (icache_resp.tag_by_way[w] == phys_tag);
		end
		// way 0 wins a double hit
		hit_way = !way_hit[0];
		tlb_ready = !virtual_mode || itlb_resp.valid;
		tlb_fault = virtual_mode && itlb_resp.valid
			&& (itlb_resp.page_fault || itlb_resp.access_fault);
	end

	assign resolve_fault = resp_cycle && tlb_fault;
	assign resolve_hit = resp_cycle && !tlb_fault && tlb_ready && (|way_hit);
	assign resolve_miss = resp_cycle && !resolve_fault && !resolve_hit;

	// ------------------------------
	// parcel valids, redirect and after-PC
	always_comb begin
		end_parcel = pred_hit ? pred_parcel : parcel_idx_t'(FETCH_PARCELS - 1);
		for (int i = 0; i < FETCH_PARCELS; i++) begin
			parcel_mask[i] = (parcel_idx_t'(i) >= fetch_pc[3:1])
				&& (parcel_idx_t'(i) <= end_parcel);
		end
		redirect_mask = '0;
		if (pred_hit) begin
			redirect_mask[pred_parcel] = 1'b1;
		end
		block_base = {fetch_pc[31:4], 4'b0000};
		after_pc = pred_hit ? pred_target : block_base + pc_t'(FETCH_BYTES);
	end

	// ------------------------------
	// feedback and packet
	always_comb begin
		icache_feedback.hit_valid = resolve_hit;
		icache_feedback.hit_way = hit_way;
		icache_feedback.miss_valid = resolve_miss;
		icache_feedback.miss_tag = phys_tag;

		istream.valid = resolve_hit || resolve_fault;
		istream.valid_by_parcel = resolve_hit ? parcel_mask : '0;
		istream.redirect_by_parcel = resolve_hit ? redirect_mask : '0;
		// little endian parcels out of the hit way
		for (int i = 0; i < FETCH_PARCELS; i++) begin
			istream.parcels[i] = {icache_resp.block_by_way[hit_way][2*i+1],
				icache_resp.block_by_way[hit_way][2*i]};
		end
		istream.after_pc = after_pc;
		istream.page_fault = resolve_fault && itlb_resp.page_fault;
		istream.access_fault = resolve_fault && itlb_resp.access_fault;
	end

endmodule

/* source/fetch_btb.sv */
// branch target buffer
// 16 entries, direct mapped on PC bits 7:4, one taken branch per fetch block,
// trained by branch updates from decode
module fetch_btb (
	input logic CLK,
	input logic nRST,
	input fetch_pkg::pc_t fetch_pc,
	input fetch_pkg::branch_update_t branch_update,
	output logic pred_hit,
	output fetch_pkg::parcel_idx_t pred_parcel,
	output fetch_pkg::pc_t pred_target
);
	import fetch_pkg::*;

	logic [BTB_ENTRIES-1:0] entry_valid;
	btb_tag_t entry_tag [BTB_ENTRIES];
	parcel_idx_t entry_parcel [BTB_ENTRIES];
	pc_t entry_target [BTB_ENTRIES];

	logic [BTB_INDEX_WIDTH-1:0] lookup_idx;
	logic [BTB_INDEX_WIDTH-1:0] update_idx;
	btb_tag_t lookup_tag;
	btb_tag_t update_tag;
	parcel_idx_t update_parcel;
	logic update_match;

	// ------------------------------
	// lookup
	assign lookup_idx = fetch_pc[7:4];
	assign lookup_tag = fetch_pc[15:8];

	// branch must sit at or after the first fetched parcel
	assign pred_hit = entry_valid[lookup_idx]
		&& (entry_tag[lookup_idx] == lookup_tag)
		&& (entry_parcel[lookup_idx] >= fetch_pc[3:1]);
	assign pred_parcel = entry_parcel[lookup_idx];
	assign pred_target = entry_target[lookup_idx];

	// ------------------------------
	// update
	assign update_idx = branch_update.start_pc[7:4];
	assign update_tag = branch_update.start_pc[15:8];
	assign update_parcel = branch_update.start_pc[3:1];
	assign update_match = entry_valid[update_idx]
		&& (entry_tag[update_idx] == update_tag)
		&& (entry_parcel[update_idx] == update_parcel);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			entry_valid <= '0;
		end else if (branch_update.valid) begin
			if (branch_update.is_taken) begin
				entry_valid[update_idx] <= 1'b1;
			end else if (update_match) begin
				// not taken any more, drop it
				entry_valid[update_idx] <= 1'b0;
			end
		end
	end

	// entry payload
	always_ff @(posedge CLK) begin
		if (branch_update.valid && branch_update.is_taken) begin
			entry_tag[update_idx] <= update_tag;
			entry_parcel[update_idx] <= update_parcel;
			entry_target[update_idx] <= branch_update.target_pc;
		end
	end

endmodule

/* source/fetch_pc_control.sv */
// fetch PC control
// runs the fetch FSM, holds PC, ASID and mode, takes restarts and stall,
// and issues the TLB and cache requests
module fetch_pc_control (
	input logic CLK,
	input logic nRST,
	input fetch_pkg::rob_restart_t rob_restart,
	input fetch_pkg::decode_restart_t decode_restart,
	input logic trigger_wait_for_restart,
	input logic istream_stall,
	input logic resolve_hit,
	input logic resolve_miss,
	input logic resolve_fault,
	input fetch_pkg::pc_t after_pc,
	output fetch_pkg::pc_t fetch_pc,
	output fetch_pkg::itlb_req_t itlb_req,
	output fetch_pkg::icache_req_t icache_req,
	output logic resp_cycle
);
	import fetch_pkg::*;

	fetch_state_t state;
	fetch_state_t next_state;
	asid_t asid;
	exec_mode_t exec_mode;
	logic virtual_mode;
	logic any_restart;
	logic req_fire;

	assign any_restart = rob_restart.valid || decode_restart.valid;

	// ------------------------------
	// next state
	always_comb begin
		next_state = state;
		if (any_restart) begin
			next_state = REQ;
		end else if (trigger_wait_for_restart) begin
			next_state = WAIT_RESTART;
		end else begin
			case (state)
				REQ: begin
					if (!istream_stall) begin
						next_state = WAIT;
					end
				end
				WAIT: begin
					next_state = RESP;
				end
				RESP: begin
					if (resolve_fault) begin
						next_state = WAIT_RESTART;
					end else if (resolve_hit || resolve_miss) begin
						// a miss retries the same PC
						next_state = REQ;
					end
				end
				default: begin
					next_state = state;
				end
			endcase
		end
	end

	// ------------------------------
	// state, PC and mode registers
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= WAIT_FOR_RESTART_AT_RESET ? WAIT_RESTART : REQ;
			fetch_pc <= INIT_PC;
			asid <= INIT_ASID;
			exec_mode <= INIT_EXEC_MODE;
			virtual_mode <= INIT_VIRTUAL_MODE;
		end else begin
			state <= next_state;
			// rob restart wins over decode restart
			if (rob_restart.valid) begin
				fetch_pc <= rob_restart.pc;
				asid <= rob_restart.asid;
				exec_mode <= rob_restart.exec_mode;
				virtual_mode <= rob_restart.virtual_mode;
			end else if (decode_restart.valid) begin
				fetch_pc <= decode_restart.pc;
			end else if (resolve_hit) begin
				fetch_pc <= after_pc;
			end
		end
	end

	// ------------------------------
	// requests, one cycle in REQ
	assign req_fire = (state == REQ) && !istream_stall && !any_restart
		&& !trigger_wait_for_restart;

	always_comb begin
		// TLB only consulted in virtual mode
		itlb_req.valid = req_fire && virtual_mode;
		itlb_req.exec_mode = exec_mode;
		itlb_req.virtual_mode = virtual_mode;
		itlb_req.asid = asid;
		itlb_req.vpn = fetch_pc[31:12];
		icache_req.valid = req_fire;
		icache_req.index = fetch_pc[9:4];
	end

	// late response after a restart is dropped here
	assign resp_cycle = (state == RESP) && !any_restart;

endmodule

/* source/fetch_pkg.sv */
// fetch front end shared definitions
// widths, address types, port structs, fetch FSM states and reset values
package fetch_pkg;

	// ------------------------------
	// widths
	localparam int PC_WIDTH = 32;
	localparam int ASID_WIDTH = 9;
	localparam int VPN_WIDTH = 20;
	localparam int PPN_WIDTH = 20;
	localparam int ICACHE_INDEX_WIDTH = 6;
	// physical page plus address bits 11:10
	localparam int ICACHE_TAG_WIDTH = PPN_WIDTH + 2;
	localparam int FETCH_PARCELS = 8;
	localparam int FETCH_BYTES = 16;
	localparam int BTB_ENTRIES = 16;
	localparam int BTB_INDEX_WIDTH = 4;
	localparam int BTB_TAG_WIDTH = 8;

	typedef logic [PC_WIDTH-1:0] pc_t;
	typedef logic [ASID_WIDTH-1:0] asid_t;
	typedef logic [1:0] exec_mode_t;
	typedef logic [VPN_WIDTH-1:0] vpn_t;
	typedef logic [PPN_WIDTH-1:0] ppn_t;
	typedef logic [ICACHE_INDEX_WIDTH-1:0] icache_index_t;
	typedef logic [ICACHE_TAG_WIDTH-1:0] icache_tag_t;
	typedef logic [$clog2(FETCH_PARCELS)-1:0] parcel_idx_t;
	typedef logic [BTB_TAG_WIDTH-1:0] btb_tag_t;

	// ------------------------------
	// reset values
	localparam pc_t INIT_PC = 32'h0000_0000;
	localparam asid_t INIT_ASID = '0;
	// machine mode
	localparam exec_mode_t INIT_EXEC_MODE = 2'b11;
	localparam logic INIT_VIRTUAL_MODE = 1'b0;
	localparam logic WAIT_FOR_RESTART_AT_RESET = 1'b1;

	// ------------------------------
	// port structs
	typedef struct packed {
		logic valid;
		exec_mode_t exec_mode;
		logic virtual_mode;
		asid_t asid;
		vpn_t vpn;
	} itlb_req_t;

	typedef struct packed {
		logic valid;
		ppn_t ppn;
		logic page_fault;
		logic access_fault;
	} itlb_resp_t;

	typedef struct packed {
		logic valid;
		icache_index_t index;
	} icache_req_t;

	typedef struct packed {
		logic [1:0] valid_by_way;
		icache_tag_t [1:0] tag_by_way;
		logic [1:0][FETCH_BYTES-1:0][7:0] block_by_way;
	} icache_resp_t;

	typedef struct packed {
		logic hit_valid;
		logic hit_way;
		logic miss_valid;
		icache_tag_t miss_tag;
	} icache_feedback_t;

	// one fetch block toward decode
	typedef struct packed {
		logic valid;
		logic [FETCH_PARCELS-1:0] valid_by_parcel;
		logic [FETCH_PARCELS-1:0] redirect_by_parcel;
		logic [FETCH_PARCELS-1:0][15:0] parcels;
		pc_t after_pc;
		logic page_fault;
		logic access_fault;
	} istream_t;

	typedef struct packed {
		logic valid;
		pc_t pc;
		asid_t asid;
		exec_mode_t exec_mode;
		logic virtual_mode;
	} rob_restart_t;

	typedef struct packed {
		logic valid;
		pc_t pc;
	} decode_restart_t;

	typedef struct packed {
		logic valid;
		logic is_taken;
		pc_t start_pc;
		pc_t target_pc;
	} branch_update_t;

	typedef enum logic [1:0] {
		WAIT_RESTART,
		REQ,
		WAIT,
		RESP
	} fetch_state_t;

endpackage
